// File: verilog/boot_rom_image.svh
// boot code, one 32-bit word per entry
localparam soc_ctrl_pkg::data_t BootRomImage [soc_ctrl_pkg::RomDepth] = '{
  32'hf140_2573, // csrr a0, mhartid
  32'h0000_0597, // auipc a1, 0
  32'h0405_8593, // addi a1, a1, 64
  32'h0000_0297,
  32'h0202_8293,
  32'h3052_9073, // mtvec
  32'h0080_0313,
  32'h3043_1073, // enable msie
  32'h3003_2073,
  32'h1050_0073, // wfi
  32'hffdf_f06f, // park loop
  32'h0000_0013,
  32'h0000_0013,
  32'h0000_0013,
  32'hdead_beef,
  32'h8000_0000  // entry point of the next stage
};

// File: verilog/soc_ctrl_pkg.sv
package soc_ctrl_pkg;

  localparam int unsigned NrHarts      = 4;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned HartIdxWidth = $clog2(NrHarts);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [NrHarts-1:0]   hart_mask_t;
  typedef logic [63:0]          mtime_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam addr_t RomBase     = 32'h0001_0000;
  localparam addr_t RomLength   = 32'h0001_0000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_C000;

  localparam int unsigned RomDepth = 16; // word index from addr[5:2]

  // ----------------------------------------
  // clint register offsets
  // ----------------------------------------
  localparam addr_t MsipOffset     = 32'h0000_0000; // one word per hart
  localparam addr_t MtimecmpOffset = 32'h0000_4000; // 8 bytes per hart, low word first
  localparam addr_t MtimeOffset    = 32'h0000_BFF8; // high word at +4

  // boot window before debug requests reach the harts
  localparam int unsigned DebugHoldCycles = 500;
  localparam int unsigned DebugCntWidth   = $clog2(DebugHoldCycles + 1);

  typedef enum logic [1:0] {
    SelNone  = 2'd0,
    SelRom   = 2'd1,
    SelClint = 2'd2
  } slave_sel_e;

  // one decode rule, end address exclusive
  typedef struct packed {
    slave_sel_e idx;
    addr_t      start_addr;
    addr_t      end_addr;
  } addr_rule_t;

endpackage

// File: verilog/boot_rom.sv
`timescale 1ns/1ns

module boot_rom (
  input  logic                clk_i,
  input  logic                req_i,
  input  soc_ctrl_pkg::addr_t addr_i,
  output soc_ctrl_pkg::data_t rdata_o
);
  import soc_ctrl_pkg::*;

`include "boot_rom_image.svh"

  logic [$clog2(RomDepth)-1:0] word_idx;

  assign word_idx = addr_i[$clog2(RomDepth)+1:2]; // byte address to word index

  always_ff @(posedge clk_i) begin : p_rom_read
    if (req_i) begin
      rdata_o <= BootRomImage[word_idx];
    end
  end

endmodule

// File: verilog/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     rtc_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  soc_ctrl_pkg::addr_t      addr_i,
  input  soc_ctrl_pkg::data_t      wdata_i,
  output soc_ctrl_pkg::data_t      rdata_o,
  output soc_ctrl_pkg::hart_mask_t timer_irq_o,
  output soc_ctrl_pkg::hart_mask_t ipi_o
);
  import soc_ctrl_pkg::*;

  logic       rtc_div_q;
  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_tick;

  mtime_t     mtime_q, mtime_d;
  mtime_t     mtimecmp_q [NrHarts];
  hart_mask_t msip_q;

  addr_t                   word_addr;
  addr_t                   msip_off;
  addr_t                   cmp_off;
  logic                    hit_msip, hit_cmp, hit_mtime_lo, hit_mtime_hi;
  logic [HartIdxWidth-1:0] msip_hart, cmp_hart;
  logic                    cmp_hi;
  logic                    wr_en;
  data_t                   rdata_d;

  // ----------------------------------------
  // rtc divide and sync
  // ----------------------------------------
  always_ff @(posedge rtc_i or negedge ndmreset_n) begin : p_rtc_div
    if (!ndmreset_n) begin
      rtc_div_q <= 1'b0;
    end else begin
      rtc_div_q <= ~rtc_div_q;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_rtc_sync
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_div_q};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_tick = rtc_sync_q[1] & ~rtc_prev_q; // rising edge only

  // ----------------------------------------
  // register decode
  // ----------------------------------------
  assign word_addr    = {addr_i[AddrWidth-1:2], 2'b00};
  assign msip_off     = word_addr - MsipOffset;
  assign cmp_off      = word_addr - MtimecmpOffset;
  assign hit_msip     = msip_off < addr_t'(NrHarts * 4); // wraps high below the base
  assign hit_cmp      = cmp_off < addr_t'(NrHarts * 8);
  assign hit_mtime_lo = word_addr == MtimeOffset;
  assign hit_mtime_hi = word_addr == MtimeOffset + addr_t'(4);
  assign msip_hart    = msip_off[HartIdxWidth+1:2];
  assign cmp_hart     = cmp_off[HartIdxWidth+2:3];
  assign cmp_hi       = cmp_off[2];
  assign wr_en        = req_i & we_i;

  always_comb begin : p_mtime_next
    mtime_d = mtime_q;
    if (rtc_tick) mtime_d = mtime_q + 64'd1;
    // a write replaces the tick
    if (wr_en && hit_mtime_lo) mtime_d = {mtime_q[63:32], wdata_i};
    if (wr_en && hit_mtime_hi) mtime_d = {wdata_i, mtime_q[31:0]};
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_regs
    if (!ndmreset_n) begin
      mtime_q <= '0;
      msip_q  <= '0;
      for (int h = 0; h < NrHarts; h++) begin
        mtimecmp_q[h] <= '1; // no timer irq out of reset
      end
    end else begin
      mtime_q <= mtime_d;
      if (wr_en && hit_msip) msip_q[msip_hart] <= wdata_i[0];
      if (wr_en && hit_cmp) begin
        if (cmp_hi) mtimecmp_q[cmp_hart][63:32] <= wdata_i;
        else        mtimecmp_q[cmp_hart][31:0]  <= wdata_i;
      end
    end
  end

  always_comb begin : p_read_mux
    rdata_d = '0; // unused offsets
    if (hit_msip) begin
      rdata_d = data_t'(msip_q[msip_hart]);
    end else if (hit_cmp) begin
      rdata_d = cmp_hi ? mtimecmp_q[cmp_hart][63:32] : mtimecmp_q[cmp_hart][31:0];
    end else if (hit_mtime_lo) begin
      rdata_d = mtime_q[31:0];
    end else if (hit_mtime_hi) begin
      rdata_d = mtime_q[63:32];
    end
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

  always_comb begin : p_irq
    for (int h = 0; h < NrHarts; h++) begin
      timer_irq_o[h] = mtime_q >= mtimecmp_q[h];
    end
  end

  assign ipi_o = msip_q;

endmodule

// File: verilog/debug_req_gate.sv
`timescale 1ns/1ns

module debug_req_gate (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  soc_ctrl_pkg::hart_mask_t dbg_req_i,
  output soc_ctrl_pkg::hart_mask_t debug_req_o
);
  import soc_ctrl_pkg::*;

  logic [DebugCntWidth-1:0] hold_cnt_q;
  logic                     holding;

  assign holding = hold_cnt_q != '0;

  // counts down once after reset, then parks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_hold_cnt
    if (!ndmreset_n) begin
      hold_cnt_q <= DebugCntWidth'(DebugHoldCycles);
    end else if (holding) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // harts run boot code first
  assign debug_req_o = holding ? '0 : dbg_req_i;

endmodule

// File: verilog/periph_interconnect.sv
`timescale 1ns/1ns

module periph_interconnect (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                req_i,
  input  logic                we_i,
  input  soc_ctrl_pkg::addr_t addr_i,
  input  soc_ctrl_pkg::data_t wdata_i,
  input  soc_ctrl_pkg::data_t rom_rdata_i,
  input  soc_ctrl_pkg::data_t clint_rdata_i,
  output logic                rvalid_o,
  output soc_ctrl_pkg::data_t rdata_o,
  output logic                err_o,
  output logic                rom_req_o,
  output soc_ctrl_pkg::addr_t rom_addr_o,
  output logic                clint_req_o,
  output logic                clint_we_o,
  output soc_ctrl_pkg::addr_t clint_addr_o,
  output soc_ctrl_pkg::data_t clint_wdata_o
);
  import soc_ctrl_pkg::*;

  addr_rule_t addr_map [2];
  slave_sel_e sel;
  logic       err_d;

  logic       valid_q;
  slave_sel_e sel_q;
  logic       err_q;
  logic       we_q;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  assign addr_map[0] = '{idx: SelRom, start_addr: RomBase, end_addr: RomBase + RomLength};
  assign addr_map[1] = '{
    idx:        SelClint,
    start_addr: ClintBase,
    end_addr:   ClintBase + ClintLength
  };

  always_comb begin : p_decode
    sel = SelNone;
    for (int r = 0; r < $size(addr_map); r++) begin
      if (addr_i >= addr_map[r].start_addr && addr_i < addr_map[r].end_addr) begin
        sel = addr_map[r].idx;
      end
    end
  end

  // rom is read only
  assign err_d = req_i & ((sel == SelNone) | ((sel == SelRom) & we_i));

  assign rom_req_o     = req_i & (sel == SelRom) & ~we_i;
  assign rom_addr_o    = addr_i - RomBase;
  assign clint_req_o   = req_i & (sel == SelClint);
  assign clint_we_o    = we_i;
  assign clint_addr_o  = addr_i - ClintBase; // offset inside the region
  assign clint_wdata_o = wdata_i;

  // ----------------------------------------
  // response
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_resp_q
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      sel_q   <= SelNone;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= req_i;
      sel_q   <= sel;
      err_q   <= err_d;
      we_q    <= we_i;
    end
  end

  always_comb begin : p_resp_mux
    rdata_o = '0;
    if (valid_q && !we_q && !err_q) begin
      case (sel_q)
        SelRom:   rdata_o = rom_rdata_i;
        SelClint: rdata_o = clint_rdata_i;
        default:  rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = err_q;

endmodule

// File: verilog/soc_ctrl_subsystem.sv
`timescale 1ns/1ns

module soc_ctrl_subsystem (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     rtc_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  soc_ctrl_pkg::addr_t      addr_i,
  input  soc_ctrl_pkg::data_t      wdata_i,
  input  soc_ctrl_pkg::hart_mask_t dbg_req_i,
  output logic                     rvalid_o,
  output soc_ctrl_pkg::data_t      rdata_o,
  output logic                     err_o,
  output soc_ctrl_pkg::hart_mask_t timer_irq_o,
  output soc_ctrl_pkg::hart_mask_t ipi_o,
  output soc_ctrl_pkg::hart_mask_t debug_req_o
);
  import soc_ctrl_pkg::*;

  logic  rom_req;
  addr_t rom_addr;
  data_t rom_rdata;

  logic  clint_req;
  logic  clint_we;
  addr_t clint_addr;
  data_t clint_wdata;
  data_t clint_rdata;

  // ----------------------------------------
  // bus decode
  // ----------------------------------------
  periph_interconnect u_interconnect (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .wdata_i       ( wdata_i     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .err_o         ( err_o       ),
    .rom_req_o     ( rom_req     ),
    .rom_addr_o    ( rom_addr    ),
    .clint_req_o   ( clint_req   ),
    .clint_we_o    ( clint_we    ),
    .clint_addr_o  ( clint_addr  ),
    .clint_wdata_o ( clint_wdata )
  );

  // ----------------------------------------
  // slaves
  // ----------------------------------------
  boot_rom u_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  clint_timer u_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ), // divided inside
    .req_i       ( clint_req   ),
    .we_i        ( clint_we    ),
    .addr_i      ( clint_addr  ),
    .wdata_i     ( clint_wdata ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // debug requests held off while the harts boot
  debug_req_gate u_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .dbg_req_i   ( dbg_req_i   ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: bench/tb_soc_ctrl.sv
`timescale 1ns/1ns

module tb_soc_ctrl;
  import soc_ctrl_pkg::*;

`include "boot_rom_image.svh"

  typedef enum logic [2:0] {
    OpAccess,  // bus access, response checked one cycle later
    OpIpi,     // compare ipi_o with exp_data
    OpIrq,     // compare timer_irq_o with exp_data
    OpRtc,     // run wdata rising edges of rtc_i
    OpWait     // idle for wdata clock cycles
  } op_e;

  typedef struct packed {
    op_e   op;
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t exp_data;
    logic  exp_err;
  } entry_t;

  logic       clk_i;
  logic       ndmreset_n;
  logic       rtc_i;
  logic       req_i;
  logic       we_i;
  addr_t      addr_i;
  data_t      wdata_i;
  hart_mask_t dbg_req_i;
  logic       rvalid_o;
  data_t      rdata_o;
  logic       err_o;
  hart_mask_t timer_irq_o;
  hart_mask_t ipi_o;
  hart_mask_t debug_req_o;

  entry_t ops [$];
  integer seed           = 32'h9e80_f46b;
  int     rtc_edges_left = 0;
  logic   table_built    = 1'b0;

  soc_ctrl_subsystem u_dut (.*);

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // 40 ns rtc clock that runs only while edges are requested
  initial begin : rtc_gen
    forever begin
      wait (rtc_edges_left > 0);
      #20 rtc_i = 1'b1;
      #20 rtc_i = 1'b0;
      rtc_edges_left--;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_harts(input hart_mask_t got, input hart_mask_t exp, input string label);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, label, got, exp);
      abort_run();
    end
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  function automatic void add_entry(input op_e op, input logic we, input addr_t addr,
                                    input data_t wdata, input data_t exp_data,
                                    input logic exp_err);
    entry_t e;
    e.op       = op;
    e.we       = we;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_data = exp_data;
    e.exp_err  = exp_err;
    ops.push_back(e);
  endfunction

  task automatic build_table();
    data_t      r;
    hart_mask_t msip;
    hart_mask_t irq;
    mtime_t     mtime;
    mtime_t     cmp [NrHarts];
    addr_t      a;
    for (int i = 0; i < RomDepth; i++) begin
      add_entry(OpAccess, 1'b0, RomBase + 4 * i, '0, BootRomImage[i], 1'b0);
    end
    add_entry(OpAccess, 1'b1, RomBase + 32'h8, 32'h1234_5678, '0, 1'b1); // rom is read only
    add_entry(OpAccess, 1'b0, 32'h0300_0000, '0, '0, 1'b1);
    add_entry(OpAccess, 1'b1, 32'h0300_0000, 32'hffff_ffff, '0, 1'b1);
    add_entry(OpAccess, 0, ClintBase + ClintLength, '0, '0, 1'b1); // just past the clint
    add_entry(OpAccess, 1'b0, 32'h0000_0000, '0, '0, 1'b1);
    add_entry(OpAccess, 1'b0, ClintBase + 32'h8000, '0, '0, 1'b0); // hole inside the clint

    // software interrupts on bit 0 only
    for (int h = 0; h < NrHarts; h++) begin
      r       = $random(seed);
      msip[h] = r[0];
      add_entry(OpAccess, 1'b1, ClintBase + MsipOffset + 4 * h, r, '0, 1'b0);
    end
    add_entry(OpIpi, 1'b0, '0, '0, data_t'(msip), 1'b0);
    for (int h = 0; h < NrHarts; h++) begin
      add_entry(OpAccess, 1'b0, ClintBase + MsipOffset + 4 * h, '0, data_t'(msip[h]), 1'b0);
    end

    // compare below, equal, above, and below by the high word
    mtime = 64'h0000_0001_8000_0000;
    add_entry(OpAccess, 1'b1, ClintBase + MtimeOffset, mtime[31:0], '0, 1'b0);
    add_entry(OpAccess, 1'b1, ClintBase + MtimeOffset + 4, mtime[63:32], '0, 1'b0);
    r      = $random(seed);
    cmp[0] = mtime - 64'd1 - {48'h0, r[15:0]};
    cmp[1] = mtime;
    r      = $random(seed);
    cmp[2] = mtime + 64'd1 + {48'h0, r[15:0]};
    r      = $random(seed);
    cmp[3] = {32'h0, r};
    for (int h = 0; h < NrHarts; h++) begin
      a      = ClintBase + MtimecmpOffset + 8 * h;
      irq[h] = mtime >= cmp[h];
      add_entry(OpAccess, 1'b1, a, cmp[h][31:0], '0, 1'b0);
      add_entry(OpAccess, 1'b1, a + 4, cmp[h][63:32], '0, 1'b0);
    end
    add_entry(OpIrq, 1'b0, '0, '0, data_t'(irq), 1'b0);
    for (int h = 0; h < NrHarts; h++) begin
      a = ClintBase + MtimecmpOffset + 8 * h;
      add_entry(OpAccess, 1'b0, a, '0, cmp[h][31:0], 1'b0);
      add_entry(OpAccess, 1'b0, a + 4, '0, cmp[h][63:32], 1'b0);
    end
    add_entry(OpAccess, 1'b0, ClintBase + MtimeOffset, '0, mtime[31:0], 1'b0);
    add_entry(OpAccess, 1'b0, ClintBase + MtimeOffset + 4, '0, mtime[63:32], 1'b0);

    // time advance by 16 rtc edges for 8 ticks
    add_entry(OpAccess, 1'b1, ClintBase + MtimeOffset, '0, '0, 1'b0);
    add_entry(OpAccess, 1'b1, ClintBase + MtimeOffset + 4, '0, '0, 1'b0);
    add_entry(OpRtc, 1'b0, '0, 32'd16, '0, 1'b0);
    add_entry(OpWait, 1'b0, '0, 32'd5, '0, 1'b0);
    add_entry(OpAccess, 1'b0, ClintBase + MtimeOffset, '0, 32'd8, 1'b0);
    add_entry(OpAccess, 1'b0, ClintBase + MtimeOffset + 4, '0, '0, 1'b0);
  endtask

  task automatic run_access(input entry_t e);
    req_i   = 1'b1;
    we_i    = e.we;
    addr_i  = e.addr;
    wdata_i = e.wdata;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    if (rvalid_o !== 1'b1) begin
      $display("no response one cycle after the access to %h at %0t ns", e.addr, $time);
      abort_run();
    end
    check_err(err_o, e.exp_err, $sformatf("err_o for %h", e.addr));
    check_data(rdata_o, e.exp_data, $sformatf("rdata_o for %h", e.addr));
  endtask

  initial begin : watchdog
    int unsigned limit;
    wait (table_built);
    limit = ops.size() * 10 + DebugHoldCycles + 2000;
    repeat (limit) @(posedge clk_i);
    $display("timed out after %0d clock cycles before the tests finished", limit);
    abort_run();
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    ndmreset_n = 1'b0;
    rtc_i      = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    dbg_req_i  = '1;  // requests pending from the start
    build_table();
    table_built = 1'b1;

    repeat (8) @(posedge clk_i);
    #1;
    ndmreset_n = 1'b1;
    check_harts(timer_irq_o, '0, "timer_irq_o after reset");
    check_harts(ipi_o, '0, "ipi_o after reset");
    check_err(err_o, 1'b0, "err_o after reset");

    repeat (400) @(posedge clk_i);
    #1;
    check_harts(debug_req_o, '0, "debug_req_o at cycle 400");
    repeat (DebugHoldCycles - 401) @(posedge clk_i);
    #1;
    check_harts(debug_req_o, '0, "debug_req_o one cycle before release");
    @(posedge clk_i);
    #1;
    check_harts(debug_req_o, '1, "debug_req_o after hold-off");

    foreach (ops[i]) begin
      case (ops[i].op)
        OpAccess: run_access(ops[i]);
        OpIpi:    check_harts(ipi_o, ops[i].exp_data[NrHarts-1:0], "ipi_o");
        OpIrq:    check_harts(timer_irq_o, ops[i].exp_data[NrHarts-1:0], "timer_irq_o");
        OpRtc: begin
          rtc_edges_left = ops[i].wdata;
          wait (rtc_edges_left == 0);
        end
        default: begin
          repeat (ops[i].wdata) @(posedge clk_i);
          #1;
          check_err(rvalid_o, 1'b0, "rvalid_o with no request");
        end
      endcase
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/soc_ctrl_pkg.sv
verilog/boot_rom.sv
verilog/clint_timer.sv
verilog/debug_req_gate.sv
verilog/periph_interconnect.sv
verilog/soc_ctrl_subsystem.sv
bench/tb_soc_ctrl.sv

// File: Bender.yml
package:
  name: soc_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_ctrl_pkg.sv
      - verilog/boot_rom.sv
      - verilog/clint_timer.sv
      - verilog/debug_req_gate.sv
      - verilog/periph_interconnect.sv
      - verilog/soc_ctrl_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_soc_ctrl.sv
